// File: logic/masking_cfg.svh
`ifndef MASKING_CFG_SVH
`define MASKING_CFG_SVH

// number of shares per masked value, the design also works with 3
`define NUM_SHARES 2

// cycles through the masked inverter
`define INV_LATENCY 3

// inverter plus the output register of the S-box
`define SBOX_LATENCY (`INV_LATENCY + 1)

`endif

// File: logic/gf_pkg.sv
`default_nettype none

package gf_pkg;

    typedef logic [1:0] bv2_t;
    typedef logic [3:0] bv4_t;
    typedef logic [7:0] bv8_t;

    // GF(4) in normal basis (W^2, W), upper bit is the W^2 coefficient
    function automatic bv2_t gf4_mul(bv2_t a, bv2_t b);
        logic e;
        e = (a[1] ^ a[0]) & (b[1] ^ b[0]);
        return {e ^ (a[1] & b[1]), e ^ (a[0] & b[0])};
    endfunction

    function automatic bv2_t gf4_sq(bv2_t a);
        return {a[0], a[1]}; // also the inverse in GF(4)
    endfunction

    function automatic bv2_t gf4_scl_n(bv2_t a);
        return {a[0], a[1] ^ a[0]}; // N = W^2
    endfunction

    function automatic bv2_t gf4_sq_scl(bv2_t a);
        return {a[1], a[1] ^ a[0]};
    endfunction

    function automatic bv2_t gf4_mul_w(bv2_t a);
        return {a[1] ^ a[0], a[1]};
    endfunction

    // GF(16) over GF(4) with Z^2 + Z + N, normal basis (Z^4, Z)
    function automatic bv4_t gf16_mul(bv4_t a, bv4_t b);
        bv2_t e;
        e = gf4_scl_n(gf4_mul(a[3:2] ^ a[1:0], b[3:2] ^ b[1:0]));
        return {gf4_mul(a[3:2], b[3:2]) ^ e, gf4_mul(a[1:0], b[1:0]) ^ e};
    endfunction

    // scaling by nu = W*Z, the constant of Y^2 + Y + nu
    function automatic bv4_t gf16_scl_nu(bv4_t a);
        bv2_t s;
        s = a[3:2] ^ a[1:0];
        return {s, gf4_mul_w(a[1:0]) ^ s};
    endfunction

    function automatic bv4_t gf16_sq_scl(bv4_t a);
        bv2_t t;
        bv2_t s1;
        bv2_t s0;
        t = gf4_sq_scl(a[3:2] ^ a[1:0]);
        s1 = gf4_sq(a[3:2]) ^ t;
        s0 = gf4_sq(a[1:0]) ^ t;
        return gf16_scl_nu({s1, s0});
    endfunction

    function automatic bv4_t gf16_pow4(bv4_t a);
        return {a[1:0], a[3:2]}; // Frobenius over GF(4) swaps the halves
    endfunction

    // full GF(256) product in normal basis (Y^16, Y), only used to build the basis change
    function automatic bv8_t gf256_mul(bv8_t a, bv8_t b);
        bv4_t e;
        e = gf16_scl_nu(gf16_mul(a[7:4] ^ a[3:0], b[7:4] ^ b[3:0]));
        return {gf16_mul(a[7:4], b[7:4]) ^ e, gf16_mul(a[3:0], b[3:0]) ^ e};
    endfunction

    // a root of the AES polynomial x^8+x^4+x^3+x+1 in the tower field, 8'hff is one
    function automatic bv8_t poly_root();
        bv8_t t;
        bv8_t t2;
        bv8_t t4;
        bv8_t t8;
        for (int c = 1; c < 256; c++) begin
            t = bv8_t'(c);
            t2 = gf256_mul(t, t);
            t4 = gf256_mul(t2, t2);
            t8 = gf256_mul(t4, t4);
            if ((t8 ^ t4 ^ gf256_mul(t2, t) ^ t ^ 8'hff) == 8'h00) begin
                return t;
            end
        end
        return 8'h00;
    endfunction

    function automatic logic [7:0][7:0] calc_to_normal();
        logic [7:0][7:0] m;
        bv8_t root;
        bv8_t pw;
        root = poly_root();
        pw = 8'hff;
        for (int k = 0; k < 8; k++) begin
            m[k] = pw; // image of x^k
            pw = gf256_mul(pw, root);
        end
        return m;
    endfunction

    localparam logic [7:0][7:0] TO_NORMAL_COLS = calc_to_normal();

    function automatic bv8_t to_normal(bv8_t x);
        bv8_t y;
        y = '0;
        for (int k = 0; k < 8; k++) begin
            if (x[k]) y ^= TO_NORMAL_COLS[k];
        end
        return y;
    endfunction

    function automatic logic [7:0][7:0] calc_from_normal();
        logic [7:0][7:0] m;
        m = '0;
        for (int k = 0; k < 8; k++) begin
            for (int p = 0; p < 256; p++) begin
                if (to_normal(bv8_t'(p)) == bv8_t'(1 << k)) m[k] = bv8_t'(p);
            end
        end
        return m;
    endfunction

    localparam logic [7:0][7:0] FROM_NORMAL_COLS = calc_from_normal();

    function automatic bv8_t from_normal(bv8_t x);
        bv8_t y;
        y = '0;
        for (int k = 0; k < 8; k++) begin
            if (x[k]) y ^= FROM_NORMAL_COLS[k];
        end
        return y;
    endfunction

    // linear part of the AES affine map, polynomial basis
    function automatic bv8_t affine_lin(bv8_t x);
        bv8_t y;
        for (int i = 0; i < 8; i++) begin
            y[i] = x[i] ^ x[(i + 4) % 8] ^ x[(i + 5) % 8] ^ x[(i + 6) % 8] ^ x[(i + 7) % 8];
        end
        return y;
    endfunction

endpackage

`default_nettype wire

// File: logic/mask_pkg.sv
`default_nettype none

`include "masking_cfg.svh"

package mask_pkg;
    import gf_pkg::*;

    typedef bv8_t [`NUM_SHARES-1:0] share8_t;
    typedef bv4_t [`NUM_SHARES-1:0] share4_t;
    typedef bv2_t [`NUM_SHARES-1:0] share2_t;

    function automatic int num_quad(int n);
        return n * (n - 1) / 2;
    endfunction

    // two shares just repeat one word, more shares use a ring
    function automatic int num_zero_random(int n);
        return (n == 2) ? 1 : n;
    endfunction

    // index of the share pair (i, j) with i < j
    function automatic int pair_idx(int i, int j);
        return i * `NUM_SHARES - i * (i + 1) / 2 + j - i - 1;
    endfunction

    localparam int NUM_QUAD = num_quad(`NUM_SHARES);
    localparam int NUM_ZERO = num_zero_random(`NUM_SHARES);

    typedef struct packed {
        bv4_t [NUM_QUAD-1:0]      front_r;
        bv4_t [NUM_QUAD-1:0]      front_p;
        bv2_t [NUM_QUAD-1:0]      theta_r;
        bv4_t [NUM_QUAD-1:0]      left_p;
        bv4_t [NUM_QUAD-1:0]      right_p;
        bv4_t [NUM_ZERO-1:0]      left_zero_raw;
        bv2_t [NUM_QUAD-1:0]      back_r;
        bv2_t [3:0][NUM_QUAD-1:0] back_p;
    } inv_random_t;

endpackage

`default_nettype wire

// File: logic/share_delay.sv
`timescale 1ns/1ps
`default_nettype none

module share_delay #(
    parameter type T = logic,
    parameter int DEPTH = 1
) (
    input  logic clock,
    input  logic reset,
    input  T     d,
    output T     q
);

    T stage [DEPTH];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int k = 0; k < DEPTH; k++) begin
                stage[k] <= '0;
            end
        end else begin
            stage[0] <= d;
            for (int k = 1; k < DEPTH; k++) begin
                stage[k] <= stage[k-1];
            end
        end
    end

    assign q = stage[DEPTH-1];

endmodule

`default_nettype wire

// File: logic/zero_sharing.sv
`timescale 1ns/1ps
`default_nettype none

`include "masking_cfg.svh"

module zero_sharing #(
    parameter int WIDTH = 4
) (
    input  logic                                                   clock,
    input  logic                                                   reset,
    input  logic [mask_pkg::num_zero_random(`NUM_SHARES)-1:0][WIDTH-1:0] raw,
    output logic [`NUM_SHARES-1:0][WIDTH-1:0]                      zero
);
    import mask_pkg::*;

    localparam int NS = `NUM_SHARES;
    localparam int NZ = num_zero_random(NS);

    logic [NS-1:0][WIDTH-1:0] zero_d;

    // each raw word lands in two neighbouring shares so the XOR of all shares is zero
    always_comb begin
        for (int i = 0; i < NS; i++) begin
            if (NZ == 1) zero_d[i] = raw[0];
            else zero_d[i] = raw[i % NZ] ^ raw[(i + 1) % NZ];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) zero <= '0;
        else zero <= zero_d;
    end

endmodule

`default_nettype wire

// File: logic/masked_gf_mul.sv
`timescale 1ns/1ps
`default_nettype none

`include "masking_cfg.svh"

module masked_gf_mul #(
    parameter int WIDTH = 4,
    parameter int SKEW = 0
) (
    input  logic                                                 clock,
    input  logic                                                 reset,
    input  logic [`NUM_SHARES-1:0][WIDTH-1:0]                    a,
    input  logic [`NUM_SHARES-1:0][WIDTH-1:0]                    b,
    input  logic [mask_pkg::num_quad(`NUM_SHARES)-1:0][WIDTH-1:0] r,
    input  logic [mask_pkg::num_quad(`NUM_SHARES)-1:0][WIDTH-1:0] p,
    output logic [`NUM_SHARES-1:0][WIDTH-1:0]                    c
);
    import gf_pkg::*;
    import mask_pkg::*;

    localparam int NS = `NUM_SHARES;

    typedef logic [NS-1:0][WIDTH-1:0] vec_t;

    vec_t b_al;
    vec_t b_ref;
    logic [NS-1:0][NS-1:0][WIDTH-1:0] term_d;
    logic [NS-1:0][NS-1:0][WIDTH-1:0] term_q;

    function automatic logic [WIDTH-1:0] fmul(logic [WIDTH-1:0] x, logic [WIDTH-1:0] y);
        if (WIDTH == 2) return WIDTH'(gf4_mul(bv2_t'(x), bv2_t'(y)));
        return WIDTH'(gf16_mul(bv4_t'(x), bv4_t'(y)));
    endfunction

    generate
        if (SKEW > 0) begin : g_skew
            share_delay #(.T(vec_t), .DEPTH(SKEW)) b_delay (
                .clock(clock),
                .reset(reset),
                .d(b),
                .q(b_al)
            );
        end else begin : g_direct
            assign b_al = b;
        end
    endgenerate

    // refresh b with a sharing of zero built from the pair words
    always_comb begin
        b_ref = b_al;
        for (int i = 0; i < NS; i++) begin
            for (int j = i + 1; j < NS; j++) begin
                b_ref[i] ^= r[pair_idx(i, j)];
                b_ref[j] ^= r[pair_idx(i, j)];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NS; i++) begin
            for (int j = 0; j < NS; j++) begin
                term_d[i][j] = fmul(a[i], b_ref[j]);
                if (i < j) term_d[i][j] ^= p[pair_idx(i, j)]; // same mask cancels in (j, i)
                else if (i > j) term_d[i][j] ^= p[pair_idx(j, i)];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) term_q <= '0;
        else term_q <= term_d;
    end

    always_comb begin
        for (int i = 0; i < NS; i++) begin
            c[i] = '0;
            for (int j = 0; j < NS; j++) begin
                c[i] ^= term_q[i][j];
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/masked_gf16_theta.sv
`timescale 1ns/1ps
`default_nettype none

`include "masking_cfg.svh"

module masked_gf16_theta (
    input  logic                                              clock,
    input  logic                                              reset,
    input  mask_pkg::share4_t                                 a,
    input  gf_pkg::bv2_t [mask_pkg::num_quad(`NUM_SHARES)-1:0] r,
    output mask_pkg::share2_t                                 theta
);
    import gf_pkg::*;
    import mask_pkg::*;

    localparam int NS = `NUM_SHARES;

    bv2_t [NS-1:0][NS-1:0] term_d;
    bv2_t [NS-1:0][NS-1:0] term_q;
    bv2_t                  norm;

    // norm of the nibble is hi*lo + N*(hi+lo)^2, only the product needs masking
    always_comb begin
        for (int i = 0; i < NS; i++) begin
            for (int j = 0; j < NS; j++) begin
                term_d[i][j] = gf4_mul(a[i][3:2], a[j][1:0]);
                if (i == j) term_d[i][j] ^= gf4_sq_scl(a[i][3:2] ^ a[i][1:0]);
                else if (i < j) term_d[i][j] ^= r[pair_idx(i, j)];
                else term_d[i][j] ^= r[pair_idx(j, i)];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) term_q <= '0;
        else term_q <= term_d;
    end

    always_comb begin
        for (int i = 0; i < NS; i++) begin
            norm = '0;
            for (int j = 0; j < NS; j++) begin
                norm ^= term_q[i][j];
            end
            theta[i] = gf4_sq(norm); // inverse of the norm in GF(4)
        end
    end

endmodule

`default_nettype wire

// File: logic/masked_gf256_inv.sv
`timescale 1ns/1ps
`default_nettype none

`include "masking_cfg.svh"

module masked_gf256_inv (
    input  logic                  clock,
    input  logic                  reset,
    input  mask_pkg::share8_t     a,
    input  mask_pkg::inv_random_t rnd,
    output mask_pkg::share8_t     b
);
    import gf_pkg::*;
    import mask_pkg::*;

    localparam int NS = `NUM_SHARES;

    typedef share4_t [1:0] nib_pair_t;
    typedef share2_t [3:0] half_quad_t;

    share4_t     hi_t0;
    share4_t     lo_t0;
    nib_pair_t   nib_t1;
    inv_random_t rnd_t1;
    inv_random_t rnd_t2;
    share4_t     mul_t1;
    share4_t     xor_t1;
    share4_t     d4_t1;
    share4_t     d4_left_t1;
    share4_t     zero_t1;
    share2_t     theta_t2;
    share4_t     left_t2;
    share4_t     right_t2;
    half_quad_t  half_t2;
    half_quad_t  back_t3;

    always_comb begin
        for (int i = 0; i < NS; i++) begin
            hi_t0[i] = a[i][7:4];
            lo_t0[i] = a[i][3:0];
        end
    end

    share_delay #(.T(inv_random_t), .DEPTH(1)) rnd_d1 (
        .clock(clock), .reset(reset), .d(rnd), .q(rnd_t1)
    );
    share_delay #(.T(inv_random_t), .DEPTH(1)) rnd_d2 (
        .clock(clock), .reset(reset), .d(rnd_t1), .q(rnd_t2)
    );
    share_delay #(.T(nib_pair_t), .DEPTH(1)) nib_d1 (
        .clock(clock), .reset(reset), .d({hi_t0, lo_t0}), .q(nib_t1)
    );

    masked_gf_mul #(.WIDTH(4), .SKEW(0)) mul_front (
        .clock(clock), .reset(reset),
        .a(hi_t0), .b(lo_t0), .r(rnd.front_r), .p(rnd.front_p), .c(mul_t1)
    );

    zero_sharing #(.WIDTH(4)) left_zero (
        .clock(clock), .reset(reset), .raw(rnd.left_zero_raw), .zero(zero_t1)
    );

    // d = hi*lo + nu*(hi+lo)^2, then d^4 which is d^-1 up to the GF(4) norm
    always_comb begin
        for (int i = 0; i < NS; i++) begin
            xor_t1[i] = nib_t1[1][i] ^ nib_t1[0][i];
            d4_t1[i] = gf16_pow4(mul_t1[i] ^ gf16_sq_scl(xor_t1[i]));
        end
        d4_left_t1 = d4_t1 ^ zero_t1; // fresh sharing of d^4 for the left product
    end

    masked_gf16_theta c_theta (
        .clock(clock), .reset(reset), .a(d4_t1), .r(rnd_t1.theta_r), .theta(theta_t2)
    );

    masked_gf_mul #(.WIDTH(4), .SKEW(0)) mul_left (
        .clock(clock), .reset(reset),
        .a(nib_t1[1]), .b(d4_left_t1), .r(rnd_t1.front_r), .p(rnd_t1.left_p), .c(left_t2)
    );

    // low nibble enters at cycle 0 and is aligned inside the gadget
    masked_gf_mul #(.WIDTH(4), .SKEW(1)) mul_right (
        .clock(clock), .reset(reset),
        .a(d4_t1), .b(lo_t0), .r(rnd_t1.front_r), .p(rnd_t1.right_p), .c(right_t2)
    );

    // the low nibble's product forms the high output nibble and vice versa
    always_comb begin
        for (int i = 0; i < NS; i++) begin
            half_t2[3][i] = right_t2[i][3:2];
            half_t2[2][i] = right_t2[i][1:0];
            half_t2[1][i] = left_t2[i][3:2];
            half_t2[0][i] = left_t2[i][1:0];
        end
    end

    for (genvar k = 0; k < 4; k++) begin : g_back
        masked_gf_mul #(.WIDTH(2), .SKEW(0)) mul_back (
            .clock(clock), .reset(reset),
            .a(half_t2[k]), .b(theta_t2), .r(rnd_t2.back_r), .p(rnd_t2.back_p[k]),
            .c(back_t3[k])
        );
    end

    always_comb begin
        for (int i = 0; i < NS; i++) begin
            b[i] = {back_t3[3][i], back_t3[2][i], back_t3[1][i], back_t3[0][i]};
        end
    end

endmodule

`default_nettype wire

// File: logic/masked_sbox.sv
`timescale 1ns/1ps
`default_nettype none

`include "masking_cfg.svh"

module masked_sbox (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  start,
    input  mask_pkg::share8_t     x_shares,
    input  mask_pkg::inv_random_t rnd,
    output logic                  done,
    output mask_pkg::share8_t     y_shares
);
    import gf_pkg::*;
    import mask_pkg::*;

    localparam int NS = `NUM_SHARES;

    share8_t x_norm;
    share8_t inv_out;
    share8_t y_next;

    // all basis maps are linear so each share goes through on its own
    always_comb begin
        for (int i = 0; i < NS; i++) begin
            x_norm[i] = to_normal(x_shares[i]);
        end
    end

    masked_gf256_inv inv0 (
        .clock(clock),
        .reset(reset),
        .a(x_norm),
        .rnd(rnd),
        .b(inv_out)
    );

    always_comb begin
        for (int i = 0; i < NS; i++) begin
            y_next[i] = affine_lin(from_normal(inv_out[i]));
        end
        y_next[0] ^= 8'h63; // affine constant goes into one share only
    end

    always_ff @(posedge clock) begin
        if (reset) y_shares <= '0;
        else y_shares <= y_next;
    end

    share_delay #(.T(logic), .DEPTH(`SBOX_LATENCY)) start_pipe (
        .clock(clock),
        .reset(reset),
        .d(start),
        .q(done)
    );

endmodule

`default_nettype wire

// File: sim/sbox_model.svh
`ifndef SBOX_MODEL_SVH
`define SBOX_MODEL_SVH

// product in GF(2^8) with the AES polynomial x^8+x^4+x^3+x+1
function automatic logic [7:0] poly_mul(logic [7:0] a, logic [7:0] b);
    logic [7:0] p;
    logic carry;
    p = '0;
    for (int k = 0; k < 8; k++) begin
        if (b[0]) p ^= a;
        carry = a[7];
        a = a << 1;
        if (carry) a ^= 8'h1b;
        b = b >> 1;
    end
    return p;
endfunction

// x^254 is the inverse, and maps zero to zero as the S-box needs
function automatic logic [7:0] pow_254(logic [7:0] x);
    logic [7:0] result;
    logic [7:0] base;
    logic [7:0] e;
    result = 8'h01;
    base = x;
    e = 8'd254;
    for (int k = 0; k < 8; k++) begin
        if (e[k]) result = poly_mul(result, base);
        base = poly_mul(base, base);
    end
    return result;
endfunction

function automatic logic [7:0] rotl8(logic [7:0] x, int n);
    return (x << n) | (x >> (8 - n));
endfunction

function automatic logic [7:0] sbox_ref(logic [7:0] x);
    logic [7:0] b;
    b = pow_254(x);
    return b ^ rotl8(b, 1) ^ rotl8(b, 2) ^ rotl8(b, 3) ^ rotl8(b, 4) ^ 8'h63;
endfunction

`endif

// File: sim/tb_masked_sbox.sv
`timescale 1ns/1ps
`default_nettype none

`include "masking_cfg.svh"

module tb_masked_sbox;
    import mask_pkg::*;

    `include "sbox_model.svh"

    localparam int TIMEOUT_CYCLES = 20;
    localparam int START_TO_DONE = 4;

    logic        clock;
    logic        reset;
    logic        start;
    share8_t     x_shares;
    inv_random_t rnd;
    logic        done;
    share8_t     y_shares;

    integer      seed;
    int          cycle = 0;
    int          errors = 0;
    int          checks = 0;
    logic [7:0]  exp_val[$];
    int          exp_due[$];

    masked_sbox dut0 (
        .clock(clock),
        .reset(reset),
        .start(start),
        .x_shares(x_shares),
        .rnd(rnd),
        .done(done),
        .y_shares(y_shares)
    );

    always #20 clock = ~clock;

    always @(posedge clock) cycle <= cycle + 1;

    function automatic logic [7:0] share_xor(share8_t s);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < `NUM_SHARES; i++) v ^= s[i];
        return v;
    endfunction

    task automatic step();
        @(posedge clock);
        #2;
    endtask

    task automatic idle_inputs();
        start = 1'b0;
        x_shares = '0;
        rnd = '0;
    endtask

    task automatic fill_random(output inv_random_t r);
        logic [$bits(inv_random_t)-1:0] vec;
        logic [31:0] w;
        w = '0;
        for (int k = 0; k < $bits(inv_random_t); k++) begin
            if (k % 32 == 0) w = $random(seed);
            vec[k] = w[k % 32];
        end
        r = inv_random_t'(vec);
    endtask

    // share 0 absorbs the secret so the XOR of all shares is the input byte
    task automatic split_secret(input logic [7:0] secret, input bit masked, output share8_t s);
        s = '0;
        s[0] = secret;
        for (int i = 1; i < `NUM_SHARES; i++) begin
            if (masked) s[i] = 8'($random(seed));
            s[0] ^= s[i];
        end
    endtask

    // drives one start and leaves at the next cycle's drive point
    task automatic drive_item(input logic [7:0] secret, input logic [7:0] expected,
                              input bit masked);
        share8_t s;
        inv_random_t r;
        split_secret(secret, masked, s);
        if (masked) fill_random(r);
        else r = '0;
        x_shares = s;
        rnd = r;
        start = 1'b1;
        exp_val.push_back(expected);
        exp_due.push_back(cycle + START_TO_DONE);
        step();
    endtask

    task automatic collect_results(input int n);
        int waited;
        int due;
        logic [7:0] got;
        logic [7:0] expected;
        for (int k = 0; k < n; k++) begin
            waited = 0;
            @(negedge clock);
            while (!done && waited < TIMEOUT_CYCLES) begin
                @(negedge clock);
                waited++;
            end
            if (!done) begin
                $display("timeout while waiting for done on result %0d", k);
                errors++;
                exp_val.delete();
                exp_due.delete();
                return;
            end
            if (exp_val.size() == 0) begin
                $display("done pulsed with no start pending");
                errors++;
                return;
            end
            got = share_xor(y_shares);
            expected = exp_val.pop_front();
            due = exp_due.pop_front();
            checks += 2;
            assert (cycle == due) else begin
                $display("Error: done cycle got %h expected %h", cycle, due);
                errors++;
            end
            assert (got == expected) else begin
                $display("Error: y_shares got %h expected %h", got, expected);
                errors++;
            end
        end
    endtask

    task automatic check_quiet(input int n);
        repeat (n) begin
            @(negedge clock);
            checks++;
            assert (done == 1'b0) else begin
                $display("Error: done got %h expected %h", done, 1'b0);
                errors++;
            end
        end
    endtask

    task automatic exhaustive_unmasked();
        for (int v = 0; v < 256; v++) begin
            drive_item(8'(v), sbox_ref(8'(v)), 1'b0);
            idle_inputs();
            collect_results(1);
            step();
        end
    endtask

    task automatic exhaustive_masked();
        for (int v = 0; v < 256; v++) begin
            drive_item(8'(v), sbox_ref(8'(v)), 1'b1);
            idle_inputs();
            collect_results(1);
            step();
        end
    endtask

    task automatic zero_byte();
        repeat (8) begin
            drive_item(8'h00, 8'h63, 1'b1); // constant taken straight from FIPS-197
            idle_inputs();
            collect_results(1);
            step();
        end
    endtask

    task automatic back_to_back(input int n);
        logic [7:0] v;
        fork
            begin
                for (int k = 0; k < n; k++) begin
                    v = 8'($random(seed));
                    drive_item(v, sbox_ref(v), 1'b1);
                end
                idle_inputs();
            end
            collect_results(n);
        join
        step();
    endtask

    task automatic idle_gaps();
        logic [7:0] v;
        int gap;
        fork
            begin
                for (int k = 0; k < 32; k++) begin
                    v = 8'($random(seed));
                    drive_item(v, sbox_ref(v), 1'b1);
                    idle_inputs();
                    gap = $unsigned($random(seed)) % 6;
                    repeat (gap) step();
                end
            end
            collect_results(32);
        join
        check_quiet(8);
        step();
    endtask

    task automatic reset_midstream();
        logic [7:0] v;
        for (int k = 0; k < 3; k++) begin
            v = 8'($random(seed));
            drive_item(v, sbox_ref(v), 1'b1);
        end
        idle_inputs();
        reset = 1'b1;
        step();
        step();
        reset = 1'b0;
        exp_val.delete(); // the flushed items never come out
        exp_due.delete();
        checks++;
        assert (y_shares == '0) else begin
            $display("Error: y_shares got %h expected %h", y_shares, 0);
            errors++;
        end
        check_quiet(8);
        step();
        back_to_back(8);
    endtask

    initial begin
        seed = 32'h7bb3fb52;
        clock = 1'b0;
        reset = 1'b1;
        idle_inputs();
        repeat (5) @(posedge clock);
        #2;
        reset = 1'b0;
        exhaustive_unmasked();
        exhaustive_masked();
        zero_byte();
        back_to_back(64);
        idle_gaps();
        reset_midstream();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+logic/
+incdir+sim/
logic/gf_pkg.sv
logic/mask_pkg.sv
logic/share_delay.sv
logic/zero_sharing.sv
logic/masked_gf_mul.sv
logic/masked_gf16_theta.sv
logic/masked_gf256_inv.sv
logic/masked_sbox.sv
sim/tb_masked_sbox.sv
